/* dv/rvModel.svh */
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

import rvIsaPkg::*;
import cpuArchPkg::*;

// Architectural state of the reference model
logic [XLEN-1:0] modelPc;
logic [XLEN-1:0] modelRegs [2**REG_ADDR_W];
logic [XLEN-1:0] modelMem [DMEM_DEPTH];

task automatic resetModel();
    modelPc = '0;
    for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        modelRegs[i] = '0;
    end
    for (int i = 0; i < DMEM_DEPTH; i++) begin
        modelMem[i] = '0; // Data memory starts cleared
    end
endtask

// Executes one instruction and returns what the trace should show
task automatic stepModel(
    input  logic [XLEN-1:0]       inst,
    output logic                  expWe,
    output logic [REG_ADDR_W-1:0] expRd,
    output logic [XLEN-1:0]       expData
);
    logic [6:0]            op;
    logic [2:0]            f3;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       offI;
    logic [XLEN-1:0]       offS;
    logic [XLEN-1:0]       offB;
    logic [XLEN-1:0]       addr;
    logic [XLEN-1:0]       nextPc;

    op      = inst[6:0];
    f3      = inst[14:12];
    rs1     = inst[19:15];
    rs2     = inst[24:20];
    expRd   = inst[11:7];
    a       = modelRegs[rs1];
    b       = modelRegs[rs2];
    offI    = 32'($signed(inst[31:20]));
    offS    = 32'($signed({inst[31:25], inst[11:7]}));
    offB    = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
    expWe   = 1'b0;
    expData = '0;
    nextPc  = modelPc + 32'd4;
    case (op)
        opR: begin
            expWe = 1'b1;
            case (f3)
                3'b000:  expData = inst[30] ? a - b : a + b;
                3'b010:  expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b110:  expData = a | b;
                3'b111:  expData = a & b;
                default: expData = a + b;
            endcase
        end
        opImm: begin
            expWe   = 1'b1;
            expData = a + offI;
        end
        opLoad: begin
            addr    = a + offI;
            expWe   = 1'b1;
            expData = modelMem[addr[DMEM_AW+1:2]];
        end
        opStore: begin
            addr = a + offS;
            modelMem[addr[DMEM_AW+1:2]] = b;
        end
        opBranch: begin
            if (a == b) begin
                nextPc = modelPc + offB;
            end
        end
        default: begin // Unknown opcode runs as a no-op
        end
    endcase
    if (expRd == '0) begin
        expWe = 1'b0;
    end
    if (expWe) begin
        modelRegs[expRd] = expData;
    end
    modelPc = nextPc;
endtask

`endif

/* dv/tbCpu.sv */
`timescale 1ns/1ps

module tbCpu;
    `include "rvModel.svh"

    localparam int SEED_INIT      = 47219;
    localparam int PROG_LEN       = 48;
    localparam int RESET_CYCLES   = 5;
    localparam int LOAD_CYCLES    = IMEM_DEPTH + 2;
    localparam int RUN_CYCLES     = 60;
    localparam int TIMEOUT_MARGIN = 20;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + LOAD_CYCLES + RUN_CYCLES + TIMEOUT_MARGIN;
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013; // addi x0, x0, 0

    logic                  CLK = 1'b0;
    logic                  reset;
    logic                  run;
    logic                  imemWe;
    logic [IMEM_AW-1:0]    imemAddr;
    logic [XLEN-1:0]       imemData;
    logic                  retireValid;
    logic [XLEN-1:0]       retirePc;
    logic [XLEN-1:0]       retireInst;
    logic                  retireRegWe;
    logic [REG_ADDR_W-1:0] retireRd;
    logic [XLEN-1:0]       retireData;

    int                    seed;
    int                    errorCount;
    int                    checkCount;
    int                    retiredCount;
    int                    cycleCount;
    logic [XLEN-1:0]       progWords [IMEM_DEPTH];
    logic                  expWe;
    logic [REG_ADDR_W-1:0] expRd;
    logic [XLEN-1:0]       expData;

    singleCycleCpu u_dut (
        .CLK         (CLK),
        .reset       (reset),
        .run         (run),
        .imemWe      (imemWe),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireInst  (retireInst),
        .retireRegWe (retireRegWe),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    initial begin
        forever #4 CLK = ~CLK; // 8 ns period
    end

    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [XLEN-1:0] rTypeWord(input logic subBit, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3,
                                                   input logic [4:0] rd);
        return {1'b0, subBit, 5'b0, rs2, rs1, f3, rd, opR};
    endfunction

    function automatic logic [XLEN-1:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
                                                   input logic [2:0] f3, input logic [4:0] rd,
                                                   input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [XLEN-1:0] sTypeWord(input logic [11:0] imm, input logic [4:0] rs2,
                                                   input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [XLEN-1:0] bTypeWord(input logic [12:0] imm, input logic [4:0] rs2,
                                                   input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
    endfunction

    // Seeds x1 to x8, then a random mix with two illegal words
    task automatic buildProgram();
        int              illegalA;
        int              illegalB;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] word;

        for (int i = 0; i < IMEM_DEPTH; i++) begin
            progWords[i] = NOP_WORD;
        end
        for (int i = 1; i <= 8; i++) begin
            progWords[i-1] = iTypeWord(12'(randBelow(4096)), 5'd0, 3'b000, 5'(i), opImm);
        end
        illegalA = 8 + randBelow(20);
        illegalB = 28 + randBelow(20);
        for (int i = 8; i < PROG_LEN; i++) begin
            rd  = 5'(randBelow(16));
            rs1 = 5'(randBelow(16));
            rs2 = 5'(randBelow(16));
            if (i == illegalA || i == illegalB) begin
                word      = $random(seed);
                word[6:0] = 7'b0001011; // Custom opcode the decoder ignores
            end else begin
                case (randBelow(5))
                    0: begin
                        case (randBelow(5))
                            0:       word = rTypeWord(1'b0, rs2, rs1, 3'b000, rd);
                            1:       word = rTypeWord(1'b1, rs2, rs1, 3'b000, rd);
                            2:       word = rTypeWord(1'b0, rs2, rs1, 3'b111, rd);
                            3:       word = rTypeWord(1'b0, rs2, rs1, 3'b110, rd);
                            default: word = rTypeWord(1'b0, rs2, rs1, 3'b010, rd);
                        endcase
                    end
                    1: word = iTypeWord(12'(randBelow(4096)), rs1, 3'b000, rd, opImm);
                    2: word = iTypeWord(12'(randBelow(16) * 4), 5'd0, 3'b010, rd, opLoad);
                    3: word = sTypeWord(12'(randBelow(16) * 4), rs2, 5'd0);
                    default: begin
                        if (randBelow(2) == 0) begin
                            rs2 = rs1; // Taken branch
                        end
                        word = bTypeWord((randBelow(2) == 0) ? 13'd8 : 13'd12, rs2, rs1);
                    end
                endcase
            end
            progWords[i] = word;
        end
    endtask

    task automatic checkValue(input string name, input logic [XLEN-1:0] actual,
                              input logic [XLEN-1:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // Trace is stable mid-cycle
    always @(negedge CLK) begin
        checkValue("retireValid", 32'(retireValid), 32'(run));
        if (retireValid) begin
            checkValue("retirePc", retirePc, modelPc);
            checkValue("retireInst", retireInst, progWords[modelPc[IMEM_AW+1:2]]);
            stepModel(retireInst, expWe, expRd, expData);
            checkValue("retireRegWe", 32'(retireRegWe), 32'(expWe));
            checkValue("retireRd", 32'(retireRd), 32'(expRd));
            if (expWe) begin
                checkValue("retireData", retireData, expData);
            end
            retiredCount++;
        end
    end

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        seed         = SEED_INIT;
        errorCount   = 0;
        checkCount   = 0;
        retiredCount = 0;
        cycleCount   = 0;
        reset        = 1'b1;
        run          = 1'b0;
        imemWe       = 1'b0;
        imemAddr     = '0;
        imemData     = '0;
        resetModel();
        buildProgram();

        repeat (RESET_CYCLES) @(posedge CLK);
        reset <= 1'b0;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(posedge CLK);
            imemWe   <= 1'b1;
            imemAddr <= IMEM_AW'(i);
            imemData <= progWords[i];
        end
        @(posedge CLK);
        imemWe <= 1'b0;
        @(posedge CLK);
        run <= 1'b1;
        repeat (RUN_CYCLES) @(posedge CLK);
        run <= 1'b0;
        @(posedge CLK);
        @(posedge CLK);

        checkValue("retiredCount", 32'(retiredCount), 32'(RUN_CYCLES));
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* hw/cpuArchPkg.sv */
package cpuArchPkg;

    // Internal memories, both word organised
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4  // Signed compare
    } aluOpE;

    // Immediate formats
    typedef enum logic [1:0] {
        immI = 2'd0,
        immS = 2'd1,
        immB = 2'd2
    } immSelE;

endpackage

/* hw/ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf;
    import cpuArchPkg::*;

    logic   regWrite; // Register file write enable
    logic   aluSrc;   // Immediate as ALU operand B
    immSelE immSel;
    aluOpE  aluOp;
    logic   memWrite;
    logic   memToReg; // Write back the loaded word
    logic   branch;

    // Decoder side
    modport control (
        output regWrite, aluSrc, immSel, aluOp, memWrite, memToReg, branch
    );

    modport datapath (
        input regWrite, aluSrc, immSel, aluOp, memWrite, memToReg, branch
    );

endinterface

/* hw/dataMem.sv */
`timescale 1ns/1ps

module dataMem (
    input  logic                      CLK,
    input  logic                      run,
    input  logic [rvIsaPkg::XLEN-1:0] addr,
    input  logic [rvIsaPkg::XLEN-1:0] wdata,
    ctrlIf.datapath                   ctrl,
    output logic [rvIsaPkg::XLEN-1:0] rdata,
    output logic [rvIsaPkg::XLEN-1:0] wbData
);
    import rvIsaPkg::*;
    import cpuArchPkg::*;

    // Starts out cleared, so unwritten words load as zero
    logic [XLEN-1:0]    mem [DMEM_DEPTH] = '{default: '0};
    logic [DMEM_AW-1:0] wordIdx;

    assign wordIdx = addr[DMEM_AW+1:2]; // Byte address to word, wraps

    always_ff @(posedge CLK) begin
        if (run && ctrl.memWrite) begin
            mem[wordIdx] <= wdata;
        end
    end

    assign rdata = mem[wordIdx];

    // Write-back select, loaded word or ALU result
    assign wbData = ctrl.memToReg ? rdata : addr;

endmodule

/* hw/execUnit.sv */
`timescale 1ns/1ps

module execUnit (
    input  logic [rvIsaPkg::XLEN-1:0] inst,
    input  logic [rvIsaPkg::XLEN-1:0] rdata1,
    input  logic [rvIsaPkg::XLEN-1:0] rdata2,
    ctrlIf.datapath                   ctrl,
    output logic [rvIsaPkg::XLEN-1:0] imm,
    output logic [rvIsaPkg::XLEN-1:0] aluResult,
    output logic                      zero
);
    import rvIsaPkg::*;
    import cpuArchPkg::*;

    logic [XLEN-1:0] immIVal;
    logic [XLEN-1:0] immSVal;
    logic [XLEN-1:0] immBVal;
    logic [XLEN-1:0] operandB;

    // Sign-extended immediates, one per format
    assign immIVal = {{20{inst[31]}}, inst[31:20]};
    assign immSVal = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immBVal = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        case (ctrl.immSel)
            immI:    imm = immIVal;
            immS:    imm = immSVal;
            immB:    imm = immBVal; // Byte offset
            default: imm = immIVal;
        endcase
    end

    assign operandB = ctrl.aluSrc ? imm : rdata2;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd: aluResult = rdata1 + operandB;
            aluSub: aluResult = rdata1 - operandB;
            aluAnd: aluResult = rdata1 & operandB;
            aluOr:  aluResult = rdata1 | operandB;
            aluSlt: begin
                aluResult = {{(XLEN-1){1'b0}}, $signed(rdata1) < $signed(operandB)};
            end
            default: aluResult = rdata1 + operandB;
        endcase
    end

    assign zero = (aluResult == '0); // Used by beq

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
    input  logic                           CLK,
    input  logic                           reset,
    input  logic                           run,
    input  logic                           imemWe,
    input  logic [cpuArchPkg::IMEM_AW-1:0] imemAddr,
    input  logic [rvIsaPkg::XLEN-1:0]      imemData,
    input  logic                           zero,
    input  logic [rvIsaPkg::XLEN-1:0]      imm,
    ctrlIf.datapath                        ctrl,
    output logic [rvIsaPkg::XLEN-1:0]      pc,
    output logic [rvIsaPkg::XLEN-1:0]      inst
);
    import rvIsaPkg::*;
    import cpuArchPkg::*;

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] branchTarget;
    logic            takeBranch;
    logic [XLEN-1:0] nextPc;

    assign pcPlus4      = pc + XLEN'(4);
    assign branchTarget = pc + imm;  // B immediate is already in bytes
    assign takeBranch   = ctrl.branch && zero;
    assign nextPc       = takeBranch ? branchTarget : pcPlus4;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // Load port works only with the core stopped
    always_ff @(posedge CLK) begin
        if (imemWe && !run) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign inst = imem[pc[IMEM_AW+1:2]]; // Word index, wraps at 64 words

    // Sequential and branch updates keep the PC word aligned
    assert property (@(posedge CLK) disable iff (reset) pc[1:0] == 2'b00)
        else $error("fetchUnit: misaligned PC %h", pc);

endmodule

/* hw/mainControl.sv */
`timescale 1ns/1ps

module mainControl (
    input logic [rvIsaPkg::XLEN-1:0] inst,
    ctrlIf.control                   ctrl
);
    import rvIsaPkg::*;
    import cpuArchPkg::*;

    opcodeE opcode;
    funct3E funct3;
    logic   subFlag;
    aluOpE  rAluOp;

    assign opcode  = opcodeE'(inst[OPCODE_W-1:0]);
    assign funct3  = funct3E'(inst[14:12]);
    assign subFlag = inst[SUB_BIT];

    // ALU function of the R-type class
    always_comb begin
        case (funct3)
            f3AddSub: rAluOp = subFlag ? aluSub : aluAdd;
            f3Slt:    rAluOp = aluSlt;
            f3Or:     rAluOp = aluOr;
            f3And:    rAluOp = aluAnd;
            default:  rAluOp = aluAdd; // Other R functions not supported
        endcase
    end

    always_comb begin
        // Defaults double as the no-op decode
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.immSel   = immI;
        ctrl.aluOp    = aluAdd;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        case (opcode)
            opR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rAluOp;
            end
            opImm: begin // addi only
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            opStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.immSel   = immS;
                ctrl.memWrite = 1'b1;
            end
            opBranch: begin
                ctrl.immSel = immB;
                ctrl.aluOp  = aluSub; // Equal operands give zero
                ctrl.branch = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // A store never writes back and a write-back never stores
    always_comb begin
        assert final (!(ctrl.memWrite && ctrl.regWrite))
            else $error("mainControl: memWrite and regWrite both set, inst %h", inst);
    end

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                              CLK,
    input  logic                              reset,
    input  logic                              run,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0]   rs1,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0]   rs2,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0]   rd,
    input  logic [rvIsaPkg::XLEN-1:0]         wdata,
    ctrlIf.datapath                           ctrl,
    output logic [rvIsaPkg::XLEN-1:0]         rdata1,
    output logic [rvIsaPkg::XLEN-1:0]         rdata2
);
    import rvIsaPkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (run && ctrl.regWrite && rd != '0) begin
            regs[rd] <= wdata; // x0 is skipped
        end
    end

    // Combinational read ports
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // x0 holds zero from reset on, whatever the write traffic
    assert property (@(posedge CLK) disable iff (reset) regs[0] == '0)
        else $error("regFile: x0 holds %h", regs[0]);

endmodule

/* hw/rvIsaPkg.sv */
package rvIsaPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int SUB_BIT    = 30; // funct7 bit 5

    // Major opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        opR      = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeE;

    // lw/sw use the slt code (word) and beq uses the add/sub code
    typedef enum logic [FUNCT3_W-1:0] {
        f3AddSub = 3'b000,
        f3Slt    = 3'b010,
        f3Or     = 3'b110,
        f3And    = 3'b111
    } funct3E;

endpackage

/* hw/singleCycleCpu.sv */
`timescale 1ns/1ps

module singleCycleCpu (
    input  logic                              CLK,
    input  logic                              reset,
    input  logic                              run,
    input  logic                              imemWe,
    input  logic [cpuArchPkg::IMEM_AW-1:0]    imemAddr,
    input  logic [rvIsaPkg::XLEN-1:0]         imemData,
    output logic                              retireValid,
    output logic [rvIsaPkg::XLEN-1:0]         retirePc,
    output logic [rvIsaPkg::XLEN-1:0]         retireInst,
    output logic                              retireRegWe,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]   retireRd,
    output logic [rvIsaPkg::XLEN-1:0]         retireData
);
    import rvIsaPkg::*;

    ctrlIf ctrlBus ();

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       inst;
    logic [XLEN-1:0]       imm;
    logic                  zero;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    logic [XLEN-1:0]       aluResult;
    logic [XLEN-1:0]       wbData;
    logic [REG_ADDR_W-1:0] rd;

    assign rd = inst[11:7];

    mainControl u_mainControl (
        .inst (inst),
        .ctrl (ctrlBus.control)
    );

    fetchUnit u_fetchUnit (
        .CLK      (CLK),
        .reset    (reset),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .zero     (zero),
        .imm      (imm),
        .ctrl     (ctrlBus.datapath),
        .pc       (pc),
        .inst     (inst)
    );

    regFile u_regFile (
        .CLK    (CLK),
        .reset  (reset),
        .run    (run),
        .rs1    (inst[19:15]),
        .rs2    (inst[24:20]),
        .rd     (rd),
        .wdata  (wbData),
        .ctrl   (ctrlBus.datapath),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    execUnit u_execUnit (
        .inst      (inst),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .ctrl      (ctrlBus.datapath),
        .imm       (imm),
        .aluResult (aluResult),
        .zero      (zero)
    );

    dataMem u_dataMem (
        .CLK    (CLK),
        .run    (run),
        .addr   (aluResult),
        .wdata  (rdata2),
        .ctrl   (ctrlBus.datapath),
        .rdata  (),         // Only the write-back value is needed here
        .wbData (wbData)
    );

    // Retire trace, same cycle as execution
    assign retireValid = run;
    assign retirePc    = pc;
    assign retireInst  = inst;
    assign retireRegWe = ctrlBus.regWrite && (rd != '0);
    assign retireRd    = rd;
    assign retireData  = wbData;

endmodule

/* vlog.f */
+incdir+dv
hw/rvIsaPkg.sv
hw/cpuArchPkg.sv
hw/ctrlIf.sv
hw/mainControl.sv
hw/fetchUnit.sv
hw/regFile.sv
hw/execUnit.sv
hw/dataMem.sv
hw/singleCycleCpu.sv
dv/tbCpu.sv
